/* source/control.sv */
`timescale 1ns/10ps
`default_nettype none

module control (
    input  wire  [6:0]      op_code,
    input  wire  [2:0]      funct3,
    input  wire  [6:0]      funct7,
    input  wire             funct7_5,
    output riscv_pkg::ctrl_t ctrl
);

    import riscv_pkg::*;

    logic listed;

    always_comb begin
        ctrl   = '0;
        listed = 1'b1;
        case (op_code)
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_b = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = 4'b0000;    // ADDI
                    3'b010:  ctrl.alu_op = 4'b0010;    // SLTI
                    3'b111:  ctrl.alu_op = 4'b0111;    // ANDI
                    3'b110:  ctrl.alu_op = 4'b0110;    // ORI
                    3'b001:  ctrl.alu_op = 4'b0001;    // SLLI
                    3'b101:  ctrl.alu_op = 4'b0101;    // SRLI
                    3'b100:  ctrl.alu_op = 4'b0100;    // XORI
                    default: listed = 1'b0;
                endcase
            end
            op_lui: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src_b  = 1'b1;
                ctrl.mem_to_reg = 2'b01;             // Immediate straight to rd
            end
            op_op: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_5 ? 4'b1000 : 4'b0000;   // SUB or ADD
                    3'b010:  ctrl.alu_op = 4'b0010;    // SLT
                    3'b111:  ctrl.alu_op = 4'b0111;    // AND
                    3'b110:  ctrl.alu_op = 4'b0110;    // OR
                    3'b001:  ctrl.alu_op = 4'b0001;    // SLL
                    3'b101:  ctrl.alu_op = 4'b0101;    // SRL
                    default: listed = 1'b0;
                endcase
            end
            op_op_32: begin
                ctrl.reg_write = 1'b1;
                if (funct3 == 3'b000) begin
                    ctrl.alu_op = 4'b1001;           // ADDW
                end else begin
                    listed = 1'b0;
                end
            end
            op_imm_32: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_b = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = 4'b1011;    // ADDIW
                    3'b001:  ctrl.alu_op = 4'b1010;    // SLLIW
                    default: listed = 1'b0;
                endcase
            end
            op_jal, op_jalr: begin
                ctrl.pc_src     = (op_code == op_jal) ? 2'b10 : 2'b11;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src_b  = 1'b1;
                ctrl.mem_to_reg = 2'b10;             // Link address
            end
            op_branch: begin
                ctrl.pc_src = 2'b10;
                ctrl.branch = 1'b1;
                case (funct3)
                    3'b000:  {ctrl.alu_op, ctrl.b_type} = {4'b1000, 3'd1};   // BEQ
                    3'b001:  {ctrl.alu_op, ctrl.b_type} = {4'b1000, 3'd0};   // BNE
                    3'b111:  {ctrl.alu_op, ctrl.b_type} = {4'b1001, 3'd2};   // BGEU
                    3'b101:  {ctrl.alu_op, ctrl.b_type} = {4'b1010, 3'd3};   // BGE
                    3'b100:  {ctrl.alu_op, ctrl.b_type} = {4'b1010, 3'd4};   // BLT
                    3'b110:  {ctrl.alu_op, ctrl.b_type} = {4'b1001, 3'd5};   // BLTU
                    default: listed = 1'b0;
                endcase
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src_b  = 1'b1;
                ctrl.mem_to_reg = 2'b11;
                ctrl.mem_read   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_size = mem_signed_byte;     // LB
                    3'b001:  ctrl.mem_size = mem_half_word;       // LH
                    3'b010:  ctrl.mem_size = mem_word;            // LW
                    3'b100:  ctrl.mem_size = mem_unsigned_byte;   // LBU
                    3'b101:  ctrl.mem_size = mem_half_word;       // LHU shares LH code
                    3'b011:  ctrl.mem_size = mem_double_word;     // LD
                    default: listed = 1'b0;
                endcase
            end
            op_store: begin
                ctrl.alu_src_b = 1'b1;
                ctrl.mem_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_size = mem_signed_byte;     // SB
                    3'b001:  ctrl.mem_size = mem_half_word;       // SH
                    3'b010:  ctrl.mem_size = mem_word;            // SW
                    3'b011:  ctrl.mem_size = mem_double_word;     // SD
                    default: listed = 1'b0;
                endcase
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_a = 1'b1;               // pc as operand a
                ctrl.alu_src_b = 1'b1;
            end
            op_system: begin
                case (funct3)
                    3'b001, 3'b010, 3'b011: begin    // CSRRW, CSRRS, CSRRC
                        ctrl.csr_write = 1'b1;
                        ctrl.csr_read  = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = 4'b1111;
                    end
                    3'b000: begin
                        case (funct7)
                            7'b0001000, 7'b0011000, 7'b0000000: begin   // SRET, MRET, ECALL
                                ctrl.ecall_sign = 1'b1;
                                ctrl.reg_write  = 1'b1;
                            end
                            7'b0001001: ctrl = '0;   // SFENCE.VMA
                            default:    listed = 1'b0;
                        endcase
                    end
                    default: listed = 1'b0;
                endcase
            end
            default: listed = 1'b0;
        endcase
        if (!listed) begin
            ctrl           = '0;
            ctrl.ill_instr = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire                         stall,
    input  wire                         empty,
    input  wire riscv_pkg::fetch_item_t head,
    output logic                        pop,
    output logic                        dec_valid,
    output riscv_pkg::dec_item_t        dec_item
);

    import riscv_pkg::*;

    logic [ilen-1:0] ins;
    logic [xlen-1:0] imm;
    ctrl_t           ctrl;

    assign ins = head.instr;
    assign pop = !empty && !stall;

    control u_control (
        .op_code  (ins[6:0]),
        .funct3   (ins[14:12]),
        .funct7   (ins[31:25]),
        .funct7_5 (ins[30]),
        .ctrl     (ctrl)
    );

    always_comb begin
        imm = '0;
        if (!ctrl.ill_instr) begin
            case (ins[6:0])
                op_imm, op_imm_32, op_jalr, op_load, op_system:
                    imm = {{(xlen-12){ins[31]}}, ins[31:20]};
                op_store:
                    imm = {{(xlen-12){ins[31]}}, ins[31:25], ins[11:7]};
                op_branch:
                    imm = {{(xlen-12){ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                op_lui, op_auipc:
                    imm = {{(xlen-32){ins[31]}}, ins[31:12], 12'b0};
                op_jal:
                    imm = {{(xlen-20){ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                default:
                    imm = '0;                        // R type has no immediate
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_item <= '{pc: head.pc, instr: ins, imm: imm, ctrl: ctrl};
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(dec_valid) && $stable(dec_item)
    );

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               redirect_valid,
    input  wire  [riscv_pkg::xlen-1:0]        redirect_pc,
    input  wire                               full,
    output logic [riscv_pkg::xlen-1:0]        imem_addr,
    input  wire  [riscv_pkg::ilen-1:0]        imem_rdata,
    output logic                              push,
    output riscv_pkg::fetch_item_t            push_item
);

    import riscv_pkg::*;

    logic [xlen-1:0] pc;
    logic            fetch_en;

    assign imem_addr = pc;

    // Redirect cycle fetches nothing, new pc is used next cycle
    assign push = fetch_en && !full && !redirect_valid;

    assign push_item.pc    = pc;
    assign push_item.instr = imem_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;               // Starts one cycle after reset
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (push) begin
                pc <= pc + 64'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* source/front_end.sv */
`timescale 1ns/10ps
`default_nettype none

module front_end (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         redirect_valid,
    input  wire  [riscv_pkg::xlen-1:0]  redirect_pc,
    input  wire                         stall,
    output logic [riscv_pkg::xlen-1:0]  imem_addr,
    input  wire  [riscv_pkg::ilen-1:0]  imem_rdata,
    output logic                        dec_valid,
    output riscv_pkg::dec_item_t        dec_item
);

    import riscv_pkg::*;

    fetch_item_t push_item;
    fetch_item_t head;
    logic        push;
    logic        pop;
    logic        full;
    logic        empty;

    fetch_unit u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .full           (full),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .push           (push),
        .push_item      (push_item)
    );

    inst_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect_valid),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect_valid),
        .stall     (stall),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .dec_valid (dec_valid),
        .dec_item  (dec_item)
    );

endmodule

`default_nettype wire

/* source/inst_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_queue (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush,
    input  wire                        push,
    input  wire riscv_pkg::fetch_item_t push_item,
    input  wire                        pop,
    output riscv_pkg::fetch_item_t     head,
    output logic                       full,
    output logic                       empty
);

    import riscv_pkg::*;

    fetch_item_t             mem [queue_depth];
    logic [queue_addr_w-1:0] wr_ptr;
    logic [queue_addr_w-1:0] rd_ptr;
    logic [queue_addr_w:0]   count;

    // First word falls through
    assign head  = mem[rd_ptr];
    assign full  = (count == queue_depth);
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at queue_depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push with pop
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        full |-> !push
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |-> !pop
    );

endmodule

`default_nettype wire

/* source/mem_access_size.svh */
`ifndef mem_access_size_svh
`define mem_access_size_svh

localparam logic [2:0] mem_signed_byte   = 3'd0;
localparam logic [2:0] mem_half_word     = 3'd1;
localparam logic [2:0] mem_word          = 3'd2;
localparam logic [2:0] mem_unsigned_byte = 3'd3;
localparam logic [2:0] mem_double_word   = 3'd4;

`endif

/* source/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    `include "mem_access_size.svh"

    localparam int xlen         = 64;
    localparam int ilen         = 32;
    localparam int queue_depth  = 4;
    localparam int queue_addr_w = 2;

    localparam logic [xlen-1:0] reset_pc = 64'h0;

    // Base opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_32  = 7'b0111011;
    localparam logic [6:0] op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef struct packed {
        logic [1:0] pc_src;
        logic       reg_write;
        logic       csr_write;
        logic       csr_read;
        logic       ecall_sign;     // Also set for sret and mret
        logic       alu_src_a;
        logic       alu_src_b;
        logic [3:0] alu_op;
        logic [1:0] mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] mem_size;
        logic       branch;
        logic [2:0] b_type;
        logic       ill_instr;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] instr;
    } fetch_item_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [ilen-1:0] instr;
        logic [xlen-1:0] imm;
        ctrl_t           ctrl;
    } dec_item_t;

endpackage

`default_nettype wire

/* tests/tb_front_end.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_front_end;

    import riscv_pkg::*;

    logic            clk, rst_n, redirect_valid, stall, dec_valid, prev_valid;
    logic [xlen-1:0] redirect_pc, imem_addr, exp_pc;
    logic [ilen-1:0] imem_rdata;
    dec_item_t       dec_item, prev_item;
    logic [ilen-1:0] imem [0:1023];
    int              addr_tick [0:1023];         // Edge that ended the last cycle an address was out
    logic [31:0]     seed;
    int              tick_count, item_count, ill_count, prog_len, prog_a_len, redirect_tick;
    logic            check_latency, after_redirect;

    assign imem_rdata = imem[imem_addr[11:2]];

    front_end DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stall          (stall),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .dec_valid      (dec_valid),
        .dec_item       (dec_item)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic value_error(string name, logic [191:0] got, logic [191:0] exp);
        abort($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // Control word from the RV64I opcode map
    function automatic ctrl_t expect_ctrl(logic [31:0] w);
        ctrl_t      c;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        c = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        legal = 1'b1;
        case (w[6:0])
            7'h13: begin                                       // OP-IMM, alu_op follows funct3
                {c.reg_write, c.alu_src_b, c.alu_op} = {2'b11, 1'b0, f3};
                legal = (f3 != 3'd3);
            end
            7'h33: begin
                c.reg_write = 1'b1;
                c.alu_op = {f3 == 3'd0 && w[30], f3};          // SUB sets the top bit
                legal = (f3 != 3'd3) && (f3 != 3'd4);
            end
            7'h3b: begin
                {c.reg_write, c.alu_op} = 5'b1_1001;
                legal = (f3 == 3'd0);
            end
            7'h1b: begin                                       // ADDIW 1011, SLLIW 1010
                {c.reg_write, c.alu_src_b, c.alu_op} = {2'b11, 3'b101, ~f3[0]};
                legal = (f3 <= 3'd1);
            end
            7'h37: {c.reg_write, c.alu_src_b, c.mem_to_reg} = 4'b1101;
            7'h17: {c.reg_write, c.alu_src_a, c.alu_src_b} = 3'b111;
            7'h6f, 7'h67: begin
                c.pc_src = (w[6:0] == 7'h6f) ? 2'b10 : 2'b11;
                {c.reg_write, c.alu_src_b, c.mem_to_reg} = 4'b1110;
            end
            7'h63: begin
                {c.pc_src, c.branch} = 3'b101;
                case (f3)
                    3'd0:    {c.alu_op, c.b_type} = {4'b1000, 3'd1};
                    3'd1:    {c.alu_op, c.b_type} = {4'b1000, 3'd0};
                    3'd4:    {c.alu_op, c.b_type} = {4'b1010, 3'd4};
                    3'd5:    {c.alu_op, c.b_type} = {4'b1010, 3'd3};
                    3'd6:    {c.alu_op, c.b_type} = {4'b1001, 3'd5};
                    3'd7:    {c.alu_op, c.b_type} = {4'b1001, 3'd2};
                    default: legal = 1'b0;
                endcase
            end
            7'h03: begin
                {c.reg_write, c.alu_src_b, c.mem_to_reg, c.mem_read} = 5'b11111;
                case (f3)
                    3'd0:       c.mem_size = mem_signed_byte;
                    3'd1, 3'd5: c.mem_size = mem_half_word;    // LHU reports half word
                    3'd2:       c.mem_size = mem_word;
                    3'd3:       c.mem_size = mem_double_word;
                    3'd4:       c.mem_size = mem_unsigned_byte;
                    default:    legal = 1'b0;
                endcase
            end
            7'h23: begin
                {c.alu_src_b, c.mem_write} = 2'b11;
                c.mem_size = (f3 == 3'd3) ? mem_double_word : f3;
                legal = (f3 <= 3'd3);
            end
            7'h73: begin
                if (f3 >= 3'd1 && f3 <= 3'd3) begin
                    {c.reg_write, c.csr_write, c.csr_read, c.alu_op} = 7'b111_1111;
                end else if (f3 == 3'd0 && (f7 == 7'h00 || f7 == 7'h08 || f7 == 7'h18)) begin
                    {c.reg_write, c.ecall_sign} = 2'b11;
                end else begin
                    legal = (f3 == 3'd0) && (f7 == 7'h09);     // SFENCE.VMA decodes to nothing
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            c = '0;
            c.ill_instr = 1'b1;
        end
        return c;
    endfunction

    function automatic logic [63:0] expect_imm(logic [31:0] w);
        ctrl_t              c;
        logic signed [11:0] i12, s12;
        logic signed [12:0] b13;
        logic signed [20:0] j21;
        logic signed [31:0] u32;
        c = expect_ctrl(w);
        i12 = w[31:20];
        s12 = {w[31:25], w[11:7]};
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        u32 = {w[31:12], 12'h000};
        if (c.ill_instr)
            return '0;
        case (w[6:0])
            7'h13, 7'h1b, 7'h67, 7'h03, 7'h73: return 64'(i12);
            7'h23:                             return 64'(s12);
            7'h63:                             return 64'(b13);
            7'h37, 7'h17:                      return 64'(u32);
            7'h6f:                             return 64'(j21);
            default:                           return '0;
        endcase
    endfunction

    // Bits under mask are fixed, the rest are random fields
    task automatic place(logic [6:0] op, logic [2:0] f3, logic [6:0] f7, logic [31:0] mask);
        imem[prog_len] = (lcg_next() & ~mask) | ({f7, 10'b0, f3, 5'b0, op} & mask);
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++)
            imem[i] = {2'b00, i[9:0], 5'd0, 3'd0, 5'd1, 7'h13};    // ADDI x1, x0, index
        prog_len = 0;
        for (int f = 0; f < 8; f++) begin
            place(7'h13, f[2:0], 7'h00, 32'h0000_707f);
            place(7'h33, f[2:0], 7'h00, 32'hfe00_707f);
            place(7'h63, f[2:0], 7'h00, 32'h0000_707f);
            place(7'h03, f[2:0], 7'h00, 32'h0000_707f);
            place(7'h23, f[2:0], 7'h00, 32'h0000_707f);
            place(7'h73, f[2:0], 7'h00, 32'h0000_707f);
        end
        place(7'h33, 3'd0, 7'h20, 32'hfe00_707f);                   // SUB
        place(7'h3b, 3'd0, 7'h00, 32'h0000_707f);                   // ADDW
        place(7'h1b, 3'd0, 7'h00, 32'h0000_707f);                   // ADDIW
        place(7'h1b, 3'd1, 7'h00, 32'hfe00_707f);                   // SLLIW
        place(7'h37, 3'd0, 7'h00, 32'h0000_007f);
        place(7'h17, 3'd0, 7'h00, 32'h0000_007f);
        place(7'h6f, 3'd0, 7'h00, 32'h0000_007f);
        place(7'h67, 3'd0, 7'h00, 32'h0000_707f);
        place(7'h73, 3'd0, 7'h00, 32'hfe00_707f);                   // ECALL
        place(7'h73, 3'd0, 7'h08, 32'hfe00_707f);                   // SRET
        place(7'h73, 3'd0, 7'h18, 32'hfe00_707f);                   // MRET
        place(7'h73, 3'd0, 7'h09, 32'hfe00_707f);                   // SFENCE.VMA
        prog_a_len = prog_len;
        place(7'h1b, 3'd2, 7'h00, 32'h0000_707f);
        place(7'h03, 3'd7, 7'h00, 32'h0000_707f);
        place(7'h7f, 3'd0, 7'h00, 32'h0000_007f);
        place(7'h73, 3'd0, 7'h7f, 32'hfe00_707f);
    endtask

    task automatic check_item();
        logic [31:0] w;
        w = imem[exp_pc[11:2]];
        assert (dec_item.pc == exp_pc) else value_error("dec_item.pc", dec_item.pc, exp_pc);
        assert (dec_item.instr == w) else value_error("dec_item.instr", dec_item.instr, w);
        assert (dec_item.imm == expect_imm(w))
            else value_error("dec_item.imm", dec_item.imm, expect_imm(w));
        assert (dec_item.ctrl == expect_ctrl(w))
            else value_error("dec_item.ctrl", dec_item.ctrl, expect_ctrl(w));
        if (check_latency)
            assert (tick_count == addr_tick[exp_pc[11:2]] + 1)
                else abort("An item did not arrive two cycles after it was addressed");
        if (after_redirect)
            assert (tick_count - redirect_tick <= 3)
                else abort("The first item after the redirect arrived too late");
        after_redirect = 1'b0;
        ill_count += dec_item.ctrl.ill_instr;
        exp_pc += 4;
        item_count++;
    endtask

    // One clock edge, then track what that edge did to the decode output
    task automatic tick();
        logic            was_stalled, was_redirect;
        logic [xlen-1:0] target;
        was_stalled = stall;
        was_redirect = redirect_valid;
        target = redirect_pc;
        addr_tick[imem_addr[11:2]] = tick_count + 1;
        @(posedge clk);
        #2;
        tick_count++;
        if (was_redirect) begin
            assert (dec_valid == 1'b0) else value_error("dec_valid", dec_valid, 1'b0);
            exp_pc = target;
            redirect_tick = tick_count;
            after_redirect = 1'b1;
        end else if (was_stalled) begin
            assert (dec_valid == prev_valid) else value_error("dec_valid", dec_valid, prev_valid);
            assert (dec_item == prev_item) else value_error("dec_item", dec_item, prev_item);
        end else if (dec_valid) begin
            check_item();
        end
        prev_valid = dec_valid;
        prev_item = dec_item;
    endtask

    task automatic wait_items(int n, int limit, string what);
        int target;
        int waited;
        target = item_count + n;
        waited = 0;
        while (item_count < target) begin
            if (waited >= limit)
                abort({"Timeout while waiting for ", what});
            tick();
            waited++;
        end
    endtask

    task automatic reset_and_stream();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #2;
            assert (dec_valid == 1'b0) else value_error("dec_valid", dec_valid, 1'b0);
        end
        rst_n = 1'b1;
        check_latency = 1'b1;
        wait_items(4, 10, "the first items after reset");
        check_latency = 1'b0;
    endtask

    task automatic program_decode();
        wait_items(prog_a_len - item_count, 2 * prog_a_len, "the decode program");
    endtask

    task automatic illegal_decode();
        int ill_before;
        ill_before = ill_count;
        wait_items(prog_len - prog_a_len, 20, "the illegal encodings");
        assert (ill_count - ill_before == prog_len - prog_a_len)
            else value_error("ill_instr count", ill_count - ill_before, prog_len - prog_a_len);
    endtask

    task automatic stall_hold();
        stall = 1'b1;
        for (int i = 0; i < 20; i++)
            tick();
        assert (imem_addr == exp_pc + 4 * queue_depth)         // Full queue holds the pc
            else value_error("imem_addr", imem_addr, exp_pc + 4 * queue_depth);
        stall = 1'b0;
        wait_items(8, 20, "the stream after a stall");
    endtask

    task automatic redirect_in_stall();
        stall = 1'b1;
        for (int i = 0; i < 5; i++)
            tick();
        redirect_valid = 1'b1;
        redirect_pc = 64'h800;
        tick();
        redirect_valid = 1'b0;
        stall = 1'b0;
        wait_items(4, 8, "the redirect target");
    endtask

    initial begin
        rst_n = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        stall = 1'b0;
        seed = 32'd24;
        tick_count = 0;
        item_count = 0;
        ill_count = 0;
        exp_pc = reset_pc;
        check_latency = 1'b0;
        after_redirect = 1'b0;
        prev_valid = 1'b0;
        prev_item = '0;
        load_program();
        reset_and_stream();
        program_decode();
        illegal_decode();
        stall_hold();
        redirect_in_stall();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/riscv_pkg.sv
source/fetch_unit.sv
source/inst_queue.sv
source/control.sv
source/decode_stage.sv
source/front_end.sv
tests/tb_front_end.sv
